// ==== rtl/rep_types_pkg.sv ====
////////////////////////////////////////////////////////////
// Datapath widths and types for the packet replicator.
// Fixed at 16 destinations; the bit-count and encoder
// logic assume that size.
////////////////////////////////////////////////////////////

package rep_types_pkg;

	localparam int DEST_COUNT = 16;
	localparam int DEST_IDX_W = 4;
	localparam int PRI_W = 3;
	localparam int TAG_W = 8;

	// Holds 0 to DEST_COUNT.
	localparam int COPY_W = 5;

	localparam int QID_W = PRI_W + DEST_IDX_W;
	localparam int QUEUE_DEPTH = 4;

	typedef logic [DEST_COUNT-1:0] dest_vec_t;

	// Priority in the upper bits, destination index below.
	typedef logic [QID_W-1:0] qid_t;

endpackage

// ==== rtl/rep_regs_pkg.sv ====
////////////////////////////////////////////////////////////
// Register map of the replicator CSR block.
// Counters are read-only and saturate.
////////////////////////////////////////////////////////////

package rep_regs_pkg;

	localparam int WB_ADR_W = 2;
	localparam int WB_DAT_W = 32;
	localparam int CNT_W = 16;

	localparam logic [WB_ADR_W-1:0] REG_CTRL = 2'd0;
	localparam logic [WB_ADR_W-1:0] REG_PORT_MASK = 2'd1;
	localparam logic [WB_ADR_W-1:0] REG_DISCARD_CNT = 2'd2;
	localparam logic [WB_ADR_W-1:0] REG_COPY_CNT = 2'd3;

	localparam logic MCAST_EN_RST = 1'b1;
	localparam logic [15:0] PORT_MASK_RST = 16'hffff;

endpackage

// ==== rtl/rep_item_if.sv ====
////////////////////////////////////////////////////////////
// Queued request from classifier to expander.
// Transfer on valid and ready; fields held while valid.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface rep_item_if;
	import rep_types_pkg::*;

	logic valid;
	logic ready;
	dest_vec_t vec;
	logic [PRI_W-1:0] pri;
	logic [TAG_W-1:0] tag;
	logic [COPY_W-1:0] copies;

	modport producer (output valid, vec, pri, tag, copies, input ready);
	modport consumer (input valid, vec, pri, tag, copies, output ready);

endinterface

// ==== rtl/rep_classify.sv ====
////////////////////////////////////////////////////////////
// Request classifier. No input ready: a request that
// meets a full queue is discarded. discard_req comes
// two cycles after enq_req.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rep_classify (
	input  logic clk,
	input  logic rst_n,
	input  logic enq_req,
	input  logic enq_discard,
	input  rep_types_pkg::dest_vec_t enq_vec,
	input  logic [rep_types_pkg::PRI_W-1:0] enq_pri,
	input  logic [rep_types_pkg::TAG_W-1:0] enq_tag,
	input  logic mcast_en,
	input  rep_types_pkg::dest_vec_t port_mask,
	output logic discard_req,
	output logic [rep_types_pkg::TAG_W-1:0] discard_tag,
	rep_item_if.producer item
);
	import rep_types_pkg::*;

	logic req_d1;
	logic discard_d1;
	dest_vec_t vec_d1;
	logic [PRI_W-1:0] pri_d1;
	logic [TAG_W-1:0] tag_d1;
	dest_vec_t masked_vec;
	logic [COPY_W-1:0] dest_cnt;
	logic q_full;
	logic discard_set;
	logic q_wr;
	logic q_rd;
	dest_vec_t q_vec [QUEUE_DEPTH];
	logic [PRI_W-1:0] q_pri [QUEUE_DEPTH];
	logic [TAG_W-1:0] q_tag [QUEUE_DEPTH];
	logic [COPY_W-1:0] q_copies [QUEUE_DEPTH];
	logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
	logic [$clog2(QUEUE_DEPTH):0] q_count;

	// Staged pairwise bit sum.
	function automatic logic [COPY_W-1:0] bit_sum(input dest_vec_t v);
		logic [1:0] s2 [8];
		logic [2:0] s4 [4];
		logic [3:0] s8 [2];
		for (int i = 0; i < 8; i++)
			s2[i] = 2'(v[2*i]) + 2'(v[2*i+1]);
		for (int i = 0; i < 4; i++)
			s4[i] = 3'(s2[2*i]) + 3'(s2[2*i+1]);
		for (int i = 0; i < 2; i++)
			s8[i] = 4'(s4[2*i]) + 4'(s4[2*i+1]);
		return COPY_W'(s8[0]) + COPY_W'(s8[1]);
	endfunction

	assign masked_vec = vec_d1 & port_mask;
	assign dest_cnt = bit_sum(masked_vec);
	assign q_full = (q_count == ($clog2(QUEUE_DEPTH) + 1)'(QUEUE_DEPTH));
	assign discard_set = req_d1 & (discard_d1 | (dest_cnt == '0) |
		((dest_cnt > COPY_W'(1)) & ~mcast_en) | q_full);
	assign q_wr = req_d1 & ~discard_set;
	assign q_rd = item.valid & item.ready;

	// First word falls through to the interface.
	assign item.valid = (q_count != '0);
	assign item.vec = q_vec[rd_ptr];
	assign item.pri = q_pri[rd_ptr];
	assign item.tag = q_tag[rd_ptr];
	assign item.copies = q_copies[rd_ptr];

	always_ff @(posedge clk)
	begin
		discard_d1 <= enq_discard;
		vec_d1 <= enq_vec;
		pri_d1 <= enq_pri;
		tag_d1 <= enq_tag;
		if (discard_set)
			discard_tag <= tag_d1;
		if (q_wr)
		begin
			q_vec[wr_ptr] <= masked_vec;
			q_pri[wr_ptr] <= pri_d1;
			q_tag[wr_ptr] <= tag_d1;
			q_copies[wr_ptr] <= dest_cnt;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req_d1 <= 1'b0;
			discard_req <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
		end
		else
		begin
			req_d1 <= enq_req;
			discard_req <= discard_set;
			if (q_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (q_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (q_wr && !q_rd)
				q_count <= q_count + 1'b1;
			else if (q_rd && !q_wr)
				q_count <= q_count - 1'b1;
		end
	end

endmodule

// ==== rtl/rep_expand.sv ====
////////////////////////////////////////////////////////////
// Copy expander. Issues one enqueue per set destination
// bit, lowest first, one per cycle while rep_bp is low.
// A new item loads when idle or on the last copy.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rep_expand (
	input  logic clk,
	input  logic rst_n,
	input  logic rep_bp,
	output logic rep_enq_req,
	output logic rep_enq_ucast,
	output logic rep_enq_last,
	output logic [rep_types_pkg::COPY_W-1:0] rep_enq_copy_id,
	output rep_types_pkg::qid_t rep_enq_qid,
	output logic [rep_types_pkg::TAG_W-1:0] rep_enq_tag,
	rep_item_if.consumer item
);
	import rep_types_pkg::*;

	logic busy;
	dest_vec_t rem_vec;
	logic [PRI_W-1:0] cur_pri;
	logic [TAG_W-1:0] cur_tag;
	logic [COPY_W-1:0] cur_copies;
	logic [COPY_W-1:0] copy_id;
	logic [DEST_IDX_W-1:0] dest_idx;
	logic last_copy;
	logic load;

	// Index of the lowest set bit.
	function automatic logic [DEST_IDX_W-1:0] low_idx(input dest_vec_t v);
		logic [DEST_IDX_W-1:0] idx;
		idx = '0;
		for (int i = DEST_COUNT - 1; i >= 0; i--)
		begin
			if (v[i])
				idx = DEST_IDX_W'(i);
		end
		return idx;
	endfunction

	assign dest_idx = low_idx(rem_vec);
	assign last_copy = (copy_id == cur_copies - COPY_W'(1));

	assign rep_enq_req = busy & ~rep_bp;
	assign rep_enq_last = rep_enq_req & last_copy;
	assign rep_enq_ucast = rep_enq_req & (cur_copies == COPY_W'(1));
	assign rep_enq_copy_id = copy_id;
	assign rep_enq_qid = {cur_pri, dest_idx};
	assign rep_enq_tag = cur_tag;

	assign item.ready = ~busy | (rep_enq_req & last_copy);
	assign load = item.valid & item.ready;

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			rem_vec <= item.vec;
			cur_pri <= item.pri;
			cur_tag <= item.tag;
			cur_copies <= item.copies;
		end
		else if (rep_enq_req)
			// Drops the lowest set bit.
			rem_vec <= rem_vec & (rem_vec - 1'b1);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			copy_id <= '0;
		end
		else if (load)
		begin
			busy <= 1'b1;
			copy_id <= '0;
		end
		else if (rep_enq_req)
		begin
			busy <= ~last_copy;
			copy_id <= copy_id + 1'b1;
		end
	end

endmodule

// ==== rtl/rep_csr.sv ====
////////////////////////////////////////////////////////////
// Wishbone classic registers. Ack and read data come one
// cycle after the strobe. Counter writes are ignored.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rep_csr (
	input  logic clk,
	input  logic rst_n,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [rep_regs_pkg::WB_ADR_W-1:0] wb_adr,
	input  logic [rep_regs_pkg::WB_DAT_W-1:0] wb_dat_w,
	input  logic discard_evt,
	input  logic copy_evt,
	output logic [rep_regs_pkg::WB_DAT_W-1:0] wb_dat_r,
	output logic wb_ack,
	output logic mcast_en,
	output rep_types_pkg::dest_vec_t port_mask
);
	import rep_types_pkg::*;
	import rep_regs_pkg::*;

	logic access;
	logic [CNT_W-1:0] discard_cnt;
	logic [CNT_W-1:0] copy_cnt;
	logic [WB_DAT_W-1:0] rd_mux;

	// One ack per strobe.
	assign access = wb_cyc & wb_stb & ~wb_ack;

	always_comb
	begin
		case (wb_adr)
			REG_CTRL:        rd_mux = {{(WB_DAT_W-1){1'b0}}, mcast_en};
			REG_PORT_MASK:   rd_mux = {{(WB_DAT_W-DEST_COUNT){1'b0}}, port_mask};
			REG_DISCARD_CNT: rd_mux = {{(WB_DAT_W-CNT_W){1'b0}}, discard_cnt};
			default:         rd_mux = {{(WB_DAT_W-CNT_W){1'b0}}, copy_cnt};
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (access)
			wb_dat_r <= rd_mux;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_ack <= 1'b0;
			mcast_en <= MCAST_EN_RST;
			port_mask <= PORT_MASK_RST;
			discard_cnt <= '0;
			copy_cnt <= '0;
		end
		else
		begin
			wb_ack <= access;
			if (access && wb_we && wb_adr == REG_CTRL)
				mcast_en <= wb_dat_w[0];
			if (access && wb_we && wb_adr == REG_PORT_MASK)
				port_mask <= wb_dat_w[DEST_COUNT-1:0];
			// Saturate at all ones.
			if (discard_evt && discard_cnt != '1)
				discard_cnt <= discard_cnt + 1'b1;
			if (copy_evt && copy_cnt != '1)
				copy_cnt <= copy_cnt + 1'b1;
		end
	end

endmodule

// ==== rtl/replicator_top.sv ====
////////////////////////////////////////////////////////////
// Packet replicator top. enq_req has no ready; overflow
// shows up on discard_req. Wishbone classic, one access
// at a time.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module replicator_top (
	input  logic clk,
	input  logic rst_n,
	input  logic enq_req,
	input  logic enq_discard,
	input  rep_types_pkg::dest_vec_t enq_vec,
	input  logic [rep_types_pkg::PRI_W-1:0] enq_pri,
	input  logic [rep_types_pkg::TAG_W-1:0] enq_tag,
	input  logic rep_bp,
	output logic rep_enq_req,
	output logic rep_enq_ucast,
	output logic rep_enq_last,
	output logic [rep_types_pkg::COPY_W-1:0] rep_enq_copy_id,
	output rep_types_pkg::qid_t rep_enq_qid,
	output logic [rep_types_pkg::TAG_W-1:0] rep_enq_tag,
	output logic discard_req,
	output logic [rep_types_pkg::TAG_W-1:0] discard_tag,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [rep_regs_pkg::WB_ADR_W-1:0] wb_adr,
	input  logic [rep_regs_pkg::WB_DAT_W-1:0] wb_dat_w,
	output logic [rep_regs_pkg::WB_DAT_W-1:0] wb_dat_r,
	output logic wb_ack
);
	import rep_types_pkg::*;

	logic mcast_en;
	dest_vec_t port_mask;

	rep_item_if item_bus ();

	rep_classify u_classify (
		.clk(clk), .rst_n(rst_n),
		.enq_req(enq_req), .enq_discard(enq_discard), .enq_vec(enq_vec),
		.enq_pri(enq_pri), .enq_tag(enq_tag),
		.mcast_en(mcast_en), .port_mask(port_mask),
		.discard_req(discard_req), .discard_tag(discard_tag),
		.item(item_bus.producer)
	);

	rep_expand u_expand (
		.clk(clk), .rst_n(rst_n), .rep_bp(rep_bp),
		.rep_enq_req(rep_enq_req), .rep_enq_ucast(rep_enq_ucast),
		.rep_enq_last(rep_enq_last), .rep_enq_copy_id(rep_enq_copy_id),
		.rep_enq_qid(rep_enq_qid), .rep_enq_tag(rep_enq_tag),
		.item(item_bus.consumer)
	);

	// Every issued copy is counted.
	rep_csr u_csr (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .discard_evt(discard_req), .copy_evt(rep_enq_req),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.mcast_en(mcast_en), .port_mask(port_mask)
	);

endmodule

// ==== dv/rep_checker.sv ====
////////////////////////////////////////////////////////////
// Scoreboard for the replicator outputs. tb_top queues the
// expected requests, discards and reads in DUT order.
// Counter reads compare against the totals seen here.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rep_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic rep_enq_req,
	input  logic rep_enq_ucast,
	input  logic rep_enq_last,
	input  logic [rep_types_pkg::COPY_W-1:0] rep_enq_copy_id,
	input  rep_types_pkg::qid_t rep_enq_qid,
	input  logic [rep_types_pkg::TAG_W-1:0] rep_enq_tag,
	input  logic discard_req,
	input  logic [rep_types_pkg::TAG_W-1:0] discard_tag,
	input  logic wb_we,
	input  logic [rep_regs_pkg::WB_ADR_W-1:0] wb_adr,
	input  logic [rep_regs_pkg::WB_DAT_W-1:0] wb_dat_r,
	input  logic wb_ack
);
	import rep_types_pkg::*;
	import rep_regs_pkg::*;

	// Entry is {copies, tag, pri, masked vec}.
	logic [31:0] item_q [$];
	logic [TAG_W-1:0] discard_q [$];
	logic [WB_DAT_W-1:0] read_q [$];
	logic [31:0] cur;
	logic [31:0] want;
	dest_vec_t rem_vec;
	int copy_n = 0;
	int dest;
	int discard_total = 0;
	int copy_total = 0;
	int check_count = 0;
	int err_count = 0;

	task automatic expect_item(input dest_vec_t vec, input logic [PRI_W-1:0] pri,
		input logic [TAG_W-1:0] tag, input logic [COPY_W-1:0] copies);
		item_q.push_back({copies, tag, pri, vec});
	endtask

	task automatic expect_discard(input logic [TAG_W-1:0] tag);
		discard_q.push_back(tag);
	endtask

	task automatic expect_read(input logic [WB_DAT_W-1:0] data);
		read_q.push_back(data);
	endtask

	function automatic int outstanding();
		return item_q.size() + discard_q.size() + read_q.size();
	endfunction

	task automatic flag(input string msg);
		err_count++;
		$display("[FAIL] %0t %s", $time, msg);
	endtask

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp)
			flag($sformatf("%s: got %0h, expected %0h", what, got, exp));
	endtask

	// Copies leave in ascending destination order.
	function automatic int lowest_dest(input dest_vec_t v);
		for (int i = 0; i < DEST_COUNT; i++)
		begin
			if (v[i])
				return i;
		end
		return -1;
	endfunction

	always @(posedge clk)
	begin
		if (rst_n)
		begin
			// Reads are checked before this cycle's events are tallied.
			if (wb_ack && !wb_we)
			begin
				if (read_q.size() == 0)
					flag("read ack with no read expected");
				else
				begin
					want = read_q.pop_front();
					if (wb_adr == REG_DISCARD_CNT)
						want = 32'(discard_total);
					else if (wb_adr == REG_COPY_CNT)
						want = 32'(copy_total);
					compare("read data", wb_dat_r, want);
				end
			end
			if (discard_req)
			begin
				discard_total++;
				if (discard_q.size() == 0)
					flag("discard with no discard expected");
				else
				begin
					want = 32'(discard_q.pop_front());
					compare("discard tag", 32'(discard_tag), want);
				end
			end
			if (rep_enq_req)
			begin
				copy_total++;
				if (item_q.size() == 0)
					flag("copy issued with no request queued");
				else
				begin
					cur = item_q[0];
					if (copy_n == 0)
						rem_vec = cur[15:0];
					dest = lowest_dest(rem_vec);
					compare("copy id", 32'(rep_enq_copy_id), 32'(copy_n));
					compare("queue id", 32'(rep_enq_qid), 32'({cur[18:16], 4'(dest)}));
					compare("tag", 32'(rep_enq_tag), 32'(cur[26:19]));
					compare("last flag", 32'(rep_enq_last), 32'(copy_n == int'(cur[31:27]) - 1));
					compare("ucast flag", 32'(rep_enq_ucast), 32'(cur[31:27] == 5'd1));
					if (dest < 0)
						flag("copy beyond the destination vector");
					else
						rem_vec[dest] = 1'b0;
					copy_n++;
					if (copy_n == int'(cur[31:27]))
					begin
						void'(item_q.pop_front());
						copy_n = 0;
					end
				end
			end
		end
	end

endmodule

// ==== dv/rep_properties.sv ====
////////////////////////////////////////////////////////////
// Protocol rules of the replicator top, bound to it.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rep_properties (
	input  logic clk,
	input  logic rst_n,
	input  logic enq_req,
	input  logic rep_bp,
	input  logic rep_enq_req,
	input  logic rep_enq_last,
	input  logic rep_enq_ucast,
	input  logic discard_req,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_ack
);
	int fail_count = 0;

	copy_blocked_by_bp: assert property (@(posedge clk) disable iff (!rst_n)
		rep_bp |-> !rep_enq_req)
	else
	begin
		fail_count++;
		$error("copy issued under back-pressure");
	end

	ack_follows_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
	else
	begin
		fail_count++;
		$error("wb_ack without a strobe in the cycle before");
	end

	// Two discards in a row need two requests.
	discard_per_request: assert property (@(posedge clk) disable iff (!rst_n)
		(discard_req && $past(discard_req)) |-> ($past(enq_req, 2) && $past(enq_req, 3)))
	else
	begin
		fail_count++;
		$error("back-to-back discards from a single request");
	end

	flags_with_copy: assert property (@(posedge clk) disable iff (!rst_n)
		(rep_enq_last || rep_enq_ucast) |-> rep_enq_req)
	else
	begin
		fail_count++;
		$error("last or ucast flag without a copy");
	end

endmodule

bind replicator_top rep_properties u_props (.*);

// ==== dv/tb_top.sv ====
////////////////////////////////////////////////////////////
// Testbench for the packet replicator. Runs the operations
// in dv/rep_stim.txt; inputs change 2 ns after the rising
// edge. All output comparing is done in rep_checker.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_top;
	import rep_types_pkg::*;
	import rep_regs_pkg::*;

	localparam int FIELDS = 6;
	localparam int STIM_WORDS = 64 * FIELDS;
	localparam int TIMEOUT = 500;

	logic clk;
	logic rst_n;
	logic enq_req;
	logic enq_discard;
	dest_vec_t enq_vec;
	logic [PRI_W-1:0] enq_pri;
	logic [TAG_W-1:0] enq_tag;
	logic rep_bp;
	logic rep_enq_req;
	logic rep_enq_ucast;
	logic rep_enq_last;
	logic [COPY_W-1:0] rep_enq_copy_id;
	qid_t rep_enq_qid;
	logic [TAG_W-1:0] rep_enq_tag;
	logic discard_req;
	logic [TAG_W-1:0] discard_tag;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_ADR_W-1:0] wb_adr;
	logic [WB_DAT_W-1:0] wb_dat_w;
	logic [WB_DAT_W-1:0] wb_dat_r;
	logic wb_ack;

	logic [31:0] stim [STIM_WORDS];
	dest_vec_t model_mask;
	logic aborted;
	int seed;
	int pos;
	int gap;
	int tests;
	int errs_before;

	replicator_top DUT (.*);
	rep_checker u_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic enqueue(input logic discard, input dest_vec_t vec,
		input logic [PRI_W-1:0] pri, input logic [TAG_W-1:0] tag,
		input logic [COPY_W-1:0] copies);
		enq_req = 1'b1;
		enq_discard = discard;
		enq_vec = vec;
		enq_pri = pri;
		enq_tag = tag;
		if (copies == '0)
			u_checker.expect_discard(tag);
		else
			u_checker.expect_item(vec & model_mask, pri, tag, copies);
		@(posedge clk);
		#2;
		enq_req = 1'b0;
	endtask

	task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
		input logic [WB_DAT_W-1:0] data);
		int n;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = data;
		n = 0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
		end while (!wb_ack && n < TIMEOUT);
		if (!wb_ack)
		begin
			aborted = 1'b1;
			$display("Timeout: no wb_ack for the access at address %0d", adr);
		end
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		// Address and direction stay put until the ack is sampled.
		@(posedge clk);
		#2;
	endtask

	task automatic end_test();
		int n;
		n = 0;
		while (u_checker.outstanding() != 0 && n < TIMEOUT)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (u_checker.outstanding() != 0)
		begin
			aborted = 1'b1;
			$display("Timeout: copies, discards or reads still missing in test %0d", tests + 1);
		end
		tests++;
		if (u_checker.err_count == errs_before)
			$display("test %0d done, no errors", tests);
		else
			$display("test %0d done, %0d errors", tests, u_checker.err_count - errs_before);
		errs_before = u_checker.err_count;
	endtask

	initial
	begin
		rst_n = 1'b0;
		enq_req = 1'b0;
		enq_discard = 1'b0;
		enq_vec = '0;
		enq_pri = '0;
		enq_tag = '0;
		rep_bp = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		model_mask = PORT_MASK_RST;
		aborted = 1'b0;
		seed = 44354;
		pos = 0;
		tests = 0;
		errs_before = 0;
		$readmemh("dv/rep_stim.txt", stim);
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		while (!aborted && pos + FIELDS <= STIM_WORDS && stim[pos][3:0] != 4'h5)
		begin
			case (stim[pos][3:0])
				4'h0: enqueue(stim[pos+1][0], stim[pos+2][15:0], stim[pos+3][PRI_W-1:0],
					stim[pos+4][TAG_W-1:0], stim[pos+5][COPY_W-1:0]);
				4'h1:
				begin
					if (stim[pos+1][WB_ADR_W-1:0] == REG_PORT_MASK)
						model_mask = stim[pos+2][15:0];
					bus_access(1'b1, stim[pos+1][WB_ADR_W-1:0], stim[pos+2]);
				end
				4'h2:
				begin
					u_checker.expect_read(stim[pos+5]);
					bus_access(1'b0, stim[pos+1][WB_ADR_W-1:0], '0);
				end
				4'h3:
				begin
					rep_bp = stim[pos+1][0];
					@(posedge clk);
					#2;
				end
				4'h4: end_test();
				default:
				begin
					aborted = 1'b1;
					$display("Unknown operation %0h in stimulus entry %0d", stim[pos][3:0],
						pos / FIELDS);
				end
			endcase
			// Idle cycles between operations.
			gap = $unsigned($random(seed)) % 3;
			repeat (gap)
			begin
				@(posedge clk);
				#2;
			end
			pos += FIELDS;
		end
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests,
			u_checker.check_count, u_checker.err_count, DUT.u_props.fail_count);
		if (!aborted && u_checker.err_count == 0 && DUT.u_props.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== dv/rep_stim.txt ====
// Six hex fields per line: op a b c d exp. op 0 enqueue (a discard, b vec, c pri, d tag, exp copies,
// 0 = discard), 1 write (a adr, b data), 2 read (a adr, exp data), 3 rep_bp = a, 4 end of test, 5 end.
2 0 0 0 0 1
2 1 0 0 0 ffff
2 2 0 0 0 0
2 3 0 0 0 0
4 0 0 0 0 0
0 0 0010 5 a1 1
0 0 8421 2 b2 4
0 0 ffff 7 c3 10
4 0 0 0 0 0
0 1 0003 1 d1 0
0 0 0000 1 d2 0
1 1 00ff 0 0 0
2 1 0 0 0 00ff
0 0 0300 3 d3 0
1 0 0 0 0 0
2 0 0 0 0 0
0 0 0003 3 d4 0
0 0 0004 2 d5 1
1 0 1 0 0 0
1 1 ffff 0 0 0
4 0 0 0 0 0
3 1 0 0 0 0
0 0 0003 0 e0 2
0 0 0006 1 e1 2
0 0 000c 2 e2 2
0 0 0018 3 e3 2
0 0 0030 4 e4 2
0 0 0060 5 e5 0
3 0 0 0 0 0
4 0 0 0 0 0
2 0 0 0 0 1
2 1 0 0 0 ffff
2 2 0 0 0 0
2 3 0 0 0 0
4 0 0 0 0 0
5 0 0 0 0 0

// ==== project.f ====
rtl/rep_types_pkg.sv
rtl/rep_regs_pkg.sv
rtl/rep_item_if.sv
rtl/rep_classify.sv
rtl/rep_expand.sv
rtl/rep_csr.sv
rtl/replicator_top.sv
dv/rep_checker.sv
dv/rep_properties.sv
dv/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the packet replicator testbench.

VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
PASS_MSG = All checks passed
FAIL_MSG = Checks failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended early"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
